/* source/pcie_pkg.sv */
package pcie_pkg;

    // **********************************************************************
    // Request and completion encodings
    // **********************************************************************

    // Completer request opcode
    typedef enum logic {
        mem_rd = 1'b0,
        mem_wr = 1'b1
    } req_op_e;

    // Completion status
    typedef enum logic {
        sc = 1'b0,  // Successful completion
        ur = 1'b1   // Unsupported request
    } cpl_status_e;

    // One completer request, a single beat on the CQ stream
    typedef struct packed {
        req_op_e     op;
        logic [2:0]  bar_id;
        logic [11:0] addr;      // Dword address inside the BAR
        logic [7:0]  tag;
        logic [7:0]  req_id;
        logic [31:0] data;      // Write payload, ignored for reads
    } cq_req_t;

    // One completion, a single beat on the CC stream
    typedef struct packed {
        cpl_status_e status;
        logic [7:0]  tag;
        logic [7:0]  req_id;
        logic [31:0] data;
    } cc_cpl_t;

    // **********************************************************************
    // BAR decode and register map
    // **********************************************************************

    localparam logic [2:0] BAR_ID_REGS = 3'd0;  // Control registers
    localparam logic [2:0] BAR_ID_RAM  = 3'd2;  // Scratch RAM

    // BAR0 dword indices
    typedef enum logic [11:0] {
        reg_id       = 12'd0,
        reg_scratch  = 12'd1,
        reg_wr_count = 12'd2,
        reg_irq      = 12'd3
    } reg_idx_e;

    // Identification word returned by reg_id
    localparam logic [31:0] CORE_ID = 32'h0ec0_0001;

    // Width of the interrupt vector number
    localparam int MSIX_VEC_WIDTH = 2;

endpackage

/* source/bar_regs.sv */
`timescale 1ns/10ps

module bar_regs (
    input  logic                                clk,
    input  logic                                rst,

    // Access strobe from the dispatcher
    input  logic                                req_en,
    input  logic                                req_wr,
    input  logic [11:0]                         req_addr,
    input  logic [31:0]                         req_data,
    output logic [31:0]                         rd_data,

    input  logic                                wr_event,   // Any counted write

    // Interrupt control and status
    output logic                                irq_trigger,
    output logic [pcie_pkg::MSIX_VEC_WIDTH-1:0] irq_vector,
    input  logic                                irq_busy,
    input  logic                                irq_fail
);

    import pcie_pkg::*;

    logic [31:0] scratch;
    logic [31:0] wr_count;
    logic        wr_irq;

    assign wr_irq = req_en && req_wr && (req_addr == reg_irq);

    // **********************************************************************
    // Writes
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_count    <= '0;
            irq_trigger <= 1'b0;
        end else begin
            irq_trigger <= wr_irq;  // Single pulse per write
            if (wr_event) begin
                wr_count <= wr_count + 32'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req_en && req_wr && (req_addr == reg_scratch)) begin
            scratch <= req_data;
        end
        if (wr_irq) begin
            irq_vector <= req_data[MSIX_VEC_WIDTH-1:0];
        end
    end

    // **********************************************************************
    // Registered read
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (req_en && !req_wr) begin
            case (req_addr)
                reg_id:       rd_data <= CORE_ID;
                reg_scratch:  rd_data <= scratch;
                reg_wr_count: rd_data <= wr_count;
                reg_irq:      rd_data <= {30'd0, irq_fail, irq_busy};
                default:      rd_data <= '0;   // Unmapped
            endcase
        end
    end

endmodule

/* source/bar_ram.sv */
`timescale 1ns/10ps

module bar_ram #(
    parameter int BAR2_APERTURE = 8     // Byte address width, 3 to 14
) (
    input  logic        clk,

    // Access strobe from the dispatcher
    input  logic        req_en,
    input  logic        req_wr,
    input  logic [11:0] req_addr,       // Dword address
    input  logic [31:0] req_data,
    output logic [31:0] rd_data
);

    localparam int IDX_WIDTH = BAR2_APERTURE - 2;
    localparam int DEPTH     = 2 ** IDX_WIDTH;

    logic [31:0]          mem [DEPTH];
    logic [IDX_WIDTH-1:0] idx;

    // Upper address bits are dropped so the index wraps to the depth
    assign idx = req_addr[IDX_WIDTH-1:0];

    // **********************************************************************
    // Single port RAM
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (req_en) begin
            if (req_wr) begin
                mem[idx] <= req_data;
            end else begin
                rd_data <= mem[idx];    // One cycle read
            end
        end
    end

endmodule

/* source/cpl_gen.sv */
`timescale 1ns/10ps

module cpl_gen (
    input  logic              clk,
    input  logic              rst,

    // Completion request from the dispatcher
    input  logic              start,
    input  pcie_pkg::cc_cpl_t hdr,
    input  logic              src_sel,  // 1 selects RAM data
    input  logic [31:0]       reg_data,
    input  logic [31:0]       ram_data,

    // Completion stream
    output pcie_pkg::cc_cpl_t cc_cpl,
    output logic              cc_valid,
    input  logic              cc_ready,
    output logic              done
);

    import pcie_pkg::*;

    cc_cpl_t cpl_next;

    // **********************************************************************
    // Header and data merge
    // **********************************************************************

    always_comb begin
        cpl_next = hdr;
        if (hdr.status == ur) begin
            cpl_next.data = '0;
        end else if (src_sel) begin
            cpl_next.data = ram_data;
        end else begin
            cpl_next.data = reg_data;
        end
    end

    // **********************************************************************
    // Output register
    // **********************************************************************

    always_ff @(posedge clk) begin
        if (rst) begin
            cc_valid <= 1'b0;
        end else if (start) begin
            cc_valid <= 1'b1;
        end else if (cc_ready) begin
            cc_valid <= 1'b0;   // Transfer taken
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            cc_cpl <= cpl_next;
        end
    end

    assign done = cc_valid && cc_ready;

    // Payload holds under back-pressure
    a_cpl_stable: assert property (@(posedge clk) disable iff (rst)
        cc_valid && !cc_ready |=> cc_valid && $stable(cc_cpl));

    // The dispatcher never starts a second completion over a pending one
    a_single_cpl: assert property (@(posedge clk) disable iff (rst)
        start |-> !cc_valid);

endmodule

/* source/msix_ctrl.sv */
`timescale 1ns/10ps

module msix_ctrl (
    input  logic                                clk,
    input  logic                                rst,

    // Request from the register block
    input  logic                                trigger,
    input  logic [pcie_pkg::MSIX_VEC_WIDTH-1:0] vector,

    // Hard block interrupt interface
    input  logic                                msix_enable,
    input  logic                                msix_mask,
    input  logic                                msix_sent,
    input  logic                                msix_fail,
    output logic                                msix_int,
    output logic [pcie_pkg::MSIX_VEC_WIDTH-1:0] msix_data,

    output logic                                busy,
    output logic                                last_fail
);

    import pcie_pkg::*;

    typedef enum logic {
        idle,
        wait_ack
    } state_e;

    state_e                    state;
    logic [MSIX_VEC_WIDTH-1:0] vec_q;   // Vector held until acknowledge
    logic                      allowed;

    assign allowed   = msix_enable && !msix_mask;
    assign msix_int  = (state == idle) && trigger && allowed;
    assign busy      = (state == wait_ack);
    assign msix_data = busy ? vec_q : vector;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            last_fail <= 1'b0;
        end else begin
            case (state)
                idle: begin
                    if (trigger && allowed) begin
                        state <= wait_ack;
                    end else if (trigger) begin
                        last_fail <= 1'b1;  // Disabled or masked
                    end
                end
                wait_ack: begin
                    if (msix_fail) begin
                        state     <= idle;
                        last_fail <= 1'b1;
                    end else if (msix_sent) begin
                        state     <= idle;
                        last_fail <= 1'b0;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (msix_int) vec_q <= vector;
    end

    // The hard block only acknowledges an outstanding interrupt
    a_ack_busy: assert property (@(posedge clk) disable iff (rst)
        (msix_sent || msix_fail) |-> busy);

endmodule

/* source/example_core_pcie.sv */
`timescale 1ns/10ps

module example_core_pcie #(
    parameter int BAR2_APERTURE = 8
) (
    input  logic                                clk,
    input  logic                                rst,
    input  pcie_pkg::cq_req_t                   cq_req,
    input  logic                                cq_valid,
    output logic                                cq_ready,
    output pcie_pkg::cc_cpl_t                   cc_cpl,
    output logic                                cc_valid,
    input  logic                                cc_ready,
    input  logic                                msix_enable,
    input  logic                                msix_mask,
    output logic                                msix_int,
    output logic [pcie_pkg::MSIX_VEC_WIDTH-1:0] msix_data,
    input  logic                                msix_sent,
    input  logic                                msix_fail
);

    import pcie_pkg::*;

    typedef enum logic [1:0] {
        idle,
        issue,
        wait_cpl
    } state_e;

    state_e  state;
    cq_req_t req_q;         // Request held while it is served
    cc_cpl_t hdr_q;         // Completion header for the read in flight
    logic    src_sel_q;     // 1 selects the RAM read data
    logic    cpl_start;     // One-cycle start toward cpl_gen
    logic    cpl_done;

    logic    hit_regs;
    logic    hit_ram;
    logic    is_wr;
    logic    regs_en;
    logic    ram_en;
    logic    wr_event;

    logic [31:0]               regs_rd_data;
    logic [31:0]               ram_rd_data;
    logic                      irq_trigger;
    logic [MSIX_VEC_WIDTH-1:0] irq_vector;
    logic                      irq_busy;
    logic                      irq_fail;

    // **********************************************************************
    // BAR decode of the held request
    // **********************************************************************

    assign hit_regs = (req_q.bar_id == BAR_ID_REGS);
    assign hit_ram  = (req_q.bar_id == BAR_ID_RAM);
    assign is_wr    = (req_q.op == mem_wr);

    assign regs_en  = (state == issue) && hit_regs;
    assign ram_en   = (state == issue) && hit_ram;
    assign wr_event = (state == issue) && is_wr && (hit_regs || hit_ram);

    // Dispatcher FSM
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= idle;
            cq_ready  <= 1'b1;
            cpl_start <= 1'b0;
        end else begin
            cpl_start <= 1'b0;
            case (state)
                idle: begin
                    if (cq_valid && cq_ready) begin
                        state    <= issue;
                        cq_ready <= 1'b0;
                    end
                end
                issue: begin
                    if (is_wr) begin
                        state    <= idle;   // Writes need no completion
                        cq_ready <= 1'b1;
                    end else begin
                        state     <= wait_cpl;
                        cpl_start <= 1'b1;
                    end
                end
                wait_cpl: begin
                    if (cpl_done) begin
                        state    <= idle;
                        cq_ready <= 1'b1;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cq_valid && cq_ready) req_q <= cq_req;
        if (state == issue) begin
            hdr_q.status <= (hit_regs || hit_ram) ? sc : ur;
            hdr_q.tag    <= req_q.tag;
            hdr_q.req_id <= req_q.req_id;
            hdr_q.data   <= '0;
            src_sel_q    <= hit_ram;
        end
    end

    // **********************************************************************
    // Targets, completion and interrupt
    // **********************************************************************

    bar_regs bar_regs_inst (
        .clk(clk),
        .rst(rst),
        .req_en(regs_en),
        .req_wr(is_wr),
        .req_addr(req_q.addr),
        .req_data(req_q.data),
        .wr_event(wr_event),
        .irq_busy(irq_busy),
        .irq_fail(irq_fail),
        .rd_data(regs_rd_data),
        .irq_trigger(irq_trigger),
        .irq_vector(irq_vector)
    );

    bar_ram #(
        .BAR2_APERTURE(BAR2_APERTURE)
    ) bar_ram_inst (
        .clk(clk),
        .req_en(ram_en),
        .req_wr(is_wr),
        .req_addr(req_q.addr),
        .req_data(req_q.data),
        .rd_data(ram_rd_data)
    );

    cpl_gen cpl_gen_inst (
        .clk(clk),
        .rst(rst),
        .start(cpl_start),
        .hdr(hdr_q),
        .src_sel(src_sel_q),
        .reg_data(regs_rd_data),
        .ram_data(ram_rd_data),
        .cc_ready(cc_ready),
        .cc_cpl(cc_cpl),
        .cc_valid(cc_valid),
        .done(cpl_done)
    );

    msix_ctrl msix_ctrl_inst (
        .clk(clk),
        .rst(rst),
        .trigger(irq_trigger),
        .vector(irq_vector),
        .msix_enable(msix_enable),
        .msix_mask(msix_mask),
        .msix_sent(msix_sent),
        .msix_fail(msix_fail),
        .msix_int(msix_int),
        .msix_data(msix_data),
        .busy(irq_busy),
        .last_fail(irq_fail)
    );

    // No new request is taken while one is being served
    a_ready_idle: assert property (@(posedge clk) disable iff (rst)
        (state != idle) |-> !cq_ready);

    // A pending completion always blocks the request stream
    a_cpl_blocks: assert property (@(posedge clk) disable iff (rst)
        cc_valid |-> !cq_ready);

endmodule

/* source/fpga_core.sv */
`timescale 1ns/10ps

module fpga_core #(
    parameter int BAR2_APERTURE = 8     // BAR2 byte address width
) (
    // Clock and synchronous reset
    input  logic                                clk,
    input  logic                                rst,

    // Completer request stream
    input  pcie_pkg::cq_req_t                   cq_req,
    input  logic                                cq_valid,
    output logic                                cq_ready,

    // Completer completion stream
    output pcie_pkg::cc_cpl_t                   cc_cpl,
    output logic                                cc_valid,
    input  logic                                cc_ready,

    // MSI-X interface to the hard block
    input  logic                                msix_enable,
    input  logic                                msix_mask,
    output logic                                msix_int,
    output logic [pcie_pkg::MSIX_VEC_WIDTH-1:0] msix_data,
    input  logic                                msix_sent,
    input  logic                                msix_fail
);

    // **********************************************************************
    // Example core
    // **********************************************************************

    example_core_pcie #(
        .BAR2_APERTURE(BAR2_APERTURE)
    ) example_core_pcie_inst (
        .clk(clk),
        .rst(rst),

        // Request input
        .cq_req(cq_req),
        .cq_valid(cq_valid),
        .cq_ready(cq_ready),

        // Completion output
        .cc_cpl(cc_cpl),
        .cc_valid(cc_valid),
        .cc_ready(cc_ready),

        // Interrupt
        .msix_enable(msix_enable),
        .msix_mask(msix_mask),
        .msix_int(msix_int),
        .msix_data(msix_data),
        .msix_sent(msix_sent),
        .msix_fail(msix_fail)
    );

endmodule

/* sim/tb_vectors.svh */
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// One table row: the request, the expected completion and the interrupt model setup
typedef struct packed {
    cq_req_t     req;
    cpl_status_e exp_status;    // Reads only
    logic [31:0] exp_data;      // Reads only
    logic        stall;         // Random cc_ready back-pressure
    logic        irq_en;        // Value for msix_enable
    logic        irq_mask;      // Value for msix_mask
    logic        exp_int;       // One msix_int pulse expected
    logic        ack_fail;      // Hard block answers with msix_fail
} vec_row_t;

vec_row_t vectors[$];

function automatic void add_read(
    input logic [2:0]  bar,
    input logic [11:0] addr,
    input logic [7:0]  tag,
    input logic [7:0]  req_id,
    input cpl_status_e status,
    input logic [31:0] data,
    input logic        stall
);
    vec_row_t row;
    row            = '0;
    row.req.op     = mem_rd;
    row.req.bar_id = bar;
    row.req.addr   = addr;
    row.req.tag    = tag;
    row.req.req_id = req_id;
    row.exp_status = status;
    row.exp_data   = data;
    row.stall      = stall;
    row.irq_en     = 1'b1;
    vectors.push_back(row);
endfunction

function automatic void add_write(
    input logic [2:0]  bar,
    input logic [11:0] addr,
    input logic [31:0] data,
    input logic [7:0]  tag,
    input logic [7:0]  req_id,
    input logic        irq_en,
    input logic        irq_mask,
    input logic        exp_int,
    input logic        ack_fail
);
    vec_row_t row;
    row            = '0;
    row.req.op     = mem_wr;
    row.req.bar_id = bar;
    row.req.addr   = addr;
    row.req.data   = data;
    row.req.tag    = tag;
    row.req.req_id = req_id;
    row.irq_en     = irq_en;
    row.irq_mask   = irq_mask;
    row.exp_int    = exp_int;
    row.ack_fail   = ack_fail;
    vectors.push_back(row);
endfunction

// Expected values assume 64 RAM dwords, so 0x045 and 0x07f alias 0x005 and 0x03f
function automatic void load_vectors();
    // Reads       bar   addr     tag    req_id status data          stall
    // Writes      bar   addr     data          tag    req_id en    mask  int   fail
    add_write(3'd2, 12'h005, 32'hcafe_0005, 8'h01, 8'h11, 1'b1, 1'b0, 1'b0, 1'b0);
    add_read (3'd2, 12'h005, 8'h02, 8'h11, sc, 32'hcafe_0005, 1'b0);
    add_write(3'd2, 12'h03f, 32'h1234_003f, 8'h03, 8'h22, 1'b1, 1'b0, 1'b0, 1'b0);
    add_write(3'd2, 12'h045, 32'h5555_aaaa, 8'h04, 8'h22, 1'b1, 1'b0, 1'b0, 1'b0);
    add_read (3'd2, 12'h005, 8'h05, 8'h33, sc, 32'h5555_aaaa, 1'b1);
    add_read (3'd2, 12'h03f, 8'h06, 8'h33, sc, 32'h1234_003f, 1'b1);
    add_read (3'd2, 12'h07f, 8'h07, 8'h44, sc, 32'h1234_003f, 1'b0);
    // BAR0 register block
    add_read (3'd0, 12'h000, 8'h08, 8'h44, sc, 32'h0ec0_0001, 1'b0);
    add_write(3'd0, 12'h001, 32'ha5a5_5a5a, 8'h09, 8'h55, 1'b1, 1'b0, 1'b0, 1'b0);
    add_read (3'd0, 12'h001, 8'h0a, 8'h55, sc, 32'ha5a5_5a5a, 1'b1);
    add_write(3'd0, 12'h001, 32'h0bad_f00d, 8'h0b, 8'h66, 1'b1, 1'b0, 1'b0, 1'b0);
    add_read (3'd0, 12'h001, 8'h0c, 8'h66, sc, 32'h0bad_f00d, 1'b0);
    add_read (3'd0, 12'h002, 8'h0d, 8'h77, sc, 32'h0000_0005, 1'b0);
    add_read (3'd0, 12'h007, 8'h0e, 8'h77, sc, 32'h0000_0000, 1'b0);
    add_read (3'd0, 12'hfff, 8'h0f, 8'h88, sc, 32'h0000_0000, 1'b1);
    // Unsupported BAR
    add_read (3'd4, 12'h005, 8'h10, 8'h88, ur, 32'h0000_0000, 1'b0);
    add_write(3'd4, 12'h005, 32'hffff_ffff, 8'h11, 8'h99, 1'b1, 1'b0, 1'b0, 1'b0);
    add_read (3'd2, 12'h005, 8'h12, 8'h99, sc, 32'h5555_aaaa, 1'b0);
    add_read (3'd0, 12'h002, 8'h13, 8'haa, sc, 32'h0000_0005, 1'b0);
    // Interrupt register
    add_write(3'd0, 12'h003, 32'h0000_0002, 8'h14, 8'hbb, 1'b1, 1'b0, 1'b1, 1'b0);
    add_read (3'd0, 12'h003, 8'h15, 8'hbb, sc, 32'h0000_0000, 1'b0);
    add_write(3'd0, 12'h003, 32'h0000_0001, 8'h16, 8'hcc, 1'b1, 1'b0, 1'b1, 1'b1);
    add_read (3'd0, 12'h003, 8'h17, 8'hcc, sc, 32'h0000_0002, 1'b0);
    add_write(3'd0, 12'h003, 32'hffff_fff7, 8'h18, 8'hdd, 1'b1, 1'b0, 1'b1, 1'b0);
    add_read (3'd0, 12'h003, 8'h19, 8'hdd, sc, 32'h0000_0000, 1'b0);
    add_write(3'd0, 12'h003, 32'h0000_0002, 8'h1a, 8'hee, 1'b1, 1'b1, 1'b0, 1'b0);
    add_read (3'd0, 12'h003, 8'h1b, 8'hee, sc, 32'h0000_0002, 1'b1);
    add_write(3'd0, 12'h003, 32'h0000_0001, 8'h1c, 8'hff, 1'b0, 1'b0, 1'b0, 1'b0);
    add_read (3'd0, 12'h003, 8'h1d, 8'hff, sc, 32'h0000_0002, 1'b0);
    add_read (3'd0, 12'h002, 8'h1e, 8'h12, sc, 32'h0000_000a, 1'b0);
    add_read (3'd6, 12'h000, 8'h1f, 8'h12, ur, 32'h0000_0000, 1'b1);
endfunction

`endif

/* sim/tb_fpga_core.sv */
`timescale 1ns/10ps

module tb_fpga_core;

    import pcie_pkg::*;

    localparam int BAR2_APERTURE = 8;   // 64 dwords
    localparam int CLK_HALF      = 20;

    logic                      clk;
    logic                      rst;
    cq_req_t                   cq_req;
    logic                      cq_valid;
    logic                      cq_ready;
    cc_cpl_t                   cc_cpl;
    logic                      cc_valid;
    logic                      cc_ready;
    logic                      msix_enable;
    logic                      msix_mask;
    logic                      msix_int;
    logic [MSIX_VEC_WIDTH-1:0] msix_data;
    logic                      msix_sent;
    logic                      msix_fail;

    logic ack_pending;      // Hard block model still answering
    logic ack_fail;         // Answer for the current row
    int   pulse_count;
    int   exp_pulses;
    int   read_count;
    int   cpl_count;

    `include "tb_vectors.svh"

    fpga_core #(
        .BAR2_APERTURE(BAR2_APERTURE)
    ) dut0 (
        .clk(clk),
        .rst(rst),
        .cq_req(cq_req),
        .cq_valid(cq_valid),
        .cq_ready(cq_ready),
        .cc_cpl(cc_cpl),
        .cc_valid(cc_valid),
        .cc_ready(cc_ready),
        .msix_enable(msix_enable),
        .msix_mask(msix_mask),
        .msix_int(msix_int),
        .msix_data(msix_data),
        .msix_sent(msix_sent),
        .msix_fail(msix_fail)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] expected);
        if (got !== expected) begin
            $display("** Error: %s is 0x%h, expected 0x%h", name, got, expected);
            $display("Checks failed");
            $fatal(1);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1);
    endtask

    // ********************************************************************
    // One table row through the request and completion streams
    // ********************************************************************

    task automatic apply_row(input vec_row_t row);
        int          waited;
        int          lat;
        logic        xfer;
        logic [31:0] rnd;
        cc_cpl_t     held;
        msix_enable = row.irq_en;
        msix_mask   = row.irq_mask;
        ack_fail    = row.ack_fail;
        cq_req      = row.req;
        cq_valid    = 1'b1;
        cc_ready    = 1'b1;
        waited      = 0;
        while (!cq_ready) begin
            if (waited == 50) abort_run("Request was never accepted");
            @(negedge clk);
            waited++;
        end
        @(posedge clk);     // Accepting edge
        @(negedge clk);
        cq_valid = 1'b0;
        check_value("cq_ready", 64'(cq_ready), 64'd0);
        check_value("msix_int", 64'(msix_int), 64'd0);
        if (row.req.op == mem_wr) begin
            @(negedge clk);
            check_value("cq_ready", 64'(cq_ready), 64'd1);    // Write done
            check_value("msix_int", 64'(msix_int), 64'(row.exp_int));
            if (row.exp_int) begin
                exp_pulses++;
                check_value("msix_data", 64'(msix_data),
                            64'(row.req.data[MSIX_VEC_WIDTH-1:0]));
            end
            @(negedge clk);
            check_value("msix_int", 64'(msix_int), 64'd0); // Single cycle pulse
            check_value("cc_valid", 64'(cc_valid), 64'd0);
            waited = 0;
            while (ack_pending) begin
                if (waited == 50) abort_run("Interrupt acknowledge never finished");
                @(negedge clk);
                waited++;
            end
        end else begin
            read_count++;
            lat = 0;
            while (!cc_valid) begin
                if (lat == 50) abort_run("Completion never arrived");
                @(posedge clk);
                lat++;
                @(negedge clk);
                if (row.stall) begin
                    rnd      = $urandom;
                    cc_ready = rnd[0];
                end
            end
            if (!row.stall) check_value("cc_valid latency", 64'(lat), 64'd2);
            held = cc_cpl;
            xfer = 1'b0;
            while (!xfer) begin
                @(posedge clk);
                xfer = cc_ready;
                @(negedge clk);
                if (!xfer) begin
                    // The completion must not move while stalled
                    check_value("cc_valid", 64'(cc_valid), 64'd1);
                    check_value("cc_cpl", 64'(cc_cpl), 64'(held));
                    rnd      = $urandom;
                    cc_ready = rnd[0];
                end
            end
            cc_ready = 1'b1;
            check_value("cc_valid", 64'(cc_valid), 64'd0);
            check_value("cq_ready", 64'(cq_ready), 64'd1);
            check_value("cc_cpl.status", 64'(held.status), 64'(row.exp_status));
            check_value("cc_cpl.tag", 64'(held.tag), 64'(row.req.tag));
            check_value("cc_cpl.req_id", 64'(held.req_id), 64'(row.req.req_id));
            check_value("cc_cpl.data", 64'(held.data), 64'(row.exp_data));
        end
    endtask

    // Hard block model that answers each msix_int after a random delay
    initial begin
        int delay;
        msix_sent   = 1'b0;
        msix_fail   = 1'b0;
        ack_pending = 1'b0;
        pulse_count = 0;
        forever begin
            @(negedge clk);
            if (msix_int) begin
                pulse_count++;
                ack_pending = 1'b1;
                delay = 1 + int'($urandom % 4);
                repeat (delay) @(negedge clk);
                if (ack_fail) begin
                    msix_fail = 1'b1;
                end else begin
                    msix_sent = 1'b1;
                end
                @(negedge clk);
                msix_sent   = 1'b0;
                msix_fail   = 1'b0;
                ack_pending = 1'b0;
            end
        end
    end

    // Counts every transfer on the completion stream
    initial begin
        cpl_count = 0;
        forever begin
            @(posedge clk);
            if (!rst && cc_valid && cc_ready) cpl_count++;
        end
    end

    initial begin
        int limit;
        #1;
        limit = vectors.size() * 200 + 20;  // Reset included
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles", limit);
        $display("Checks failed");
        $fatal(1);
    end

    // ********************************************************************
    // Main sequence
    // ********************************************************************

    initial begin
        void'($urandom(32'h7d79_f41b));
        rst         = 1'b1;
        cq_req      = '0;
        cq_valid    = 1'b0;
        cc_ready    = 1'b1;
        msix_enable = 1'b0;
        msix_mask   = 1'b0;
        ack_fail    = 1'b0;
        exp_pulses  = 0;
        read_count  = 0;
        load_vectors();
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_value("cc_valid", 64'(cc_valid), 64'd0);
        check_value("msix_int", 64'(msix_int), 64'd0);
        check_value("cq_ready", 64'(cq_ready), 64'd1);
        foreach (vectors[i]) apply_row(vectors[i]);
        check_value("completion count", 64'(cpl_count), 64'(read_count));
        check_value("msix_int pulses", 64'(pulse_count), 64'(exp_pulses));
        $display("All checks passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+sim
source/pcie_pkg.sv
source/bar_regs.sv
source/bar_ram.sv
source/cpl_gen.sv
source/msix_ctrl.sv
source/example_core_pcie.sv
source/fpga_core.sv
sim/tb_fpga_core.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f tb.f --top-module tb_fpga_core

# A failing run is caught by the search below
out=$(./obj_dir/Vtb_fpga_core 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "All checks passed"; then
    exit 0
else
    exit 1
fi
